/* axi_pkg.sv */
package axi_pkg;

  // Channel widths
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 32;
  localparam int AXI_STRB_W  = AXI_DATA_W / 8;
  localparam int AXI_ID_MAX  = 8;
  localparam int AXI_LEN_W   = 8;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_RESP_W  = 2;

  // Response codes
  localparam logic [AXI_RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;

  // Only INCR bursts of 4-byte beats are served
  localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'b01;
  localparam logic [AXI_SIZE_W-1:0]  SIZE_WORD  = 3'b010;

  typedef struct packed {
    logic [AXI_ID_MAX-1:0]  id;
    logic [AXI_ADDR_W-1:0]  addr;
    logic [AXI_LEN_W-1:0]   len;
    logic [AXI_SIZE_W-1:0]  size;
    logic [AXI_BURST_W-1:0] burst;
  } axi_aw_t;

  // Read address uses the write address layout
  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_MAX-1:0] id;
    logic [AXI_RESP_W-1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_MAX-1:0] id;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_RESP_W-1:0] resp;
    logic                  last;
  } axi_r_t;

endpackage

/* host_pkg.sv */
package host_pkg;

  // LSU host-port data width
  localparam int HOST_DATA_W = 32;
  localparam int HOST_BE_W   = HOST_DATA_W / 8;

  // Request driven alongside req_valid
  typedef struct packed {
    logic [31:0]            addr;
    logic                   we;
    logic [HOST_BE_W-1:0]   be;
    logic [HOST_DATA_W-1:0] wdata;
  } host_req_t;

  // Response, one rvalid pulse per granted request
  typedef struct packed {
    logic                   rvalid;
    logic                   err;
    logic [HOST_DATA_W-1:0] rdata;
  } host_rsp_t;

endpackage

/* saxi_to_host.sv */
`timescale 1ns/100ps

module saxi_to_host
  import axi_pkg::*, host_pkg::*;
#(
  parameter int AXI_ID_WIDTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  axi_aw_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_b_t    b_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  input  axi_ar_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output host_req_t host_req_o,
  output logic      host_req_valid_o,
  input  logic      host_gnt_i,
  input  host_rsp_t host_rsp_i
);

  localparam int CNT_W = AXI_LEN_W + 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_ACT,
    ST_WR_ACT,
    ST_ISSUE,
    ST_WAIT_RSP
  } eng_state_e;

  eng_state_e state_q;
  eng_state_e state_d;

  // Latched commands, beats counted inclusively
  logic                    rd_cmd_q;
  logic [AXI_ID_WIDTH-1:0] rd_id_q;
  logic [AXI_ADDR_W-1:0]   rd_addr_q;
  logic [CNT_W-1:0]        rd_beats_q;
  logic                    wr_cmd_q;
  logic [AXI_ID_WIDTH-1:0] wr_id_q;
  logic [AXI_ADDR_W-1:0]   wr_addr_q;
  logic [CNT_W-1:0]        wr_beats_q;

  axi_w_t w_q;
  logic   cur_is_write_q;
  logic   error_seen_q;

  // Registered response channels
  axi_r_t r_q;
  logic   r_valid_q;
  axi_b_t b_q;
  logic   b_valid_q;

  logic                  aw_hs;
  logic                  ar_hs;
  logic                  w_hs;
  logic                  r_hs;
  logic                  b_hs;
  logic                  rsp_done;
  logic                  wr_last_beat;
  logic                  rd_last_beat;
  logic [AXI_RESP_W-1:0] beat_resp;

  // New bursts only when fully idle and the matching channel is free
  assign aw_ready_o = (state_q == ST_IDLE) && !rd_cmd_q && !wr_cmd_q && !b_valid_q &&
                      (aw_i.size == SIZE_WORD) && (aw_i.burst == BURST_INCR);
  assign ar_ready_o = (state_q == ST_IDLE) && !rd_cmd_q && !wr_cmd_q && !r_valid_q &&
                      (ar_i.size == SIZE_WORD) && (ar_i.burst == BURST_INCR);
  assign w_ready_o  = (state_q == ST_WR_ACT);

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign ar_hs = ar_valid_i && ar_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign r_hs  = r_valid_q && r_ready_i;
  assign b_hs  = b_valid_q && b_ready_i;

  assign rsp_done     = (state_q == ST_WAIT_RSP) && host_rsp_i.rvalid;
  assign wr_last_beat = (wr_beats_q == CNT_W'(1));
  assign rd_last_beat = (rd_beats_q == CNT_W'(1));
  // Sticky over the burst
  assign beat_resp    = (host_rsp_i.err || error_seen_q) ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_cmd_q   <= 1'b0;
      rd_beats_q <= '0;
      wr_cmd_q   <= 1'b0;
      wr_beats_q <= '0;
    end else begin
      if (ar_hs) begin
        rd_cmd_q   <= 1'b1;
        rd_beats_q <= {1'b0, ar_i.len} + CNT_W'(1);
      end else if (r_hs) begin
        // Read beat retires on the R handshake
        rd_beats_q <= rd_beats_q - CNT_W'(1);
        if (rd_last_beat) begin
          rd_cmd_q <= 1'b0;
        end
      end
      if (aw_hs) begin
        wr_cmd_q   <= 1'b1;
        wr_beats_q <= {1'b0, aw_i.len} + CNT_W'(1);
      end else if (rsp_done && cur_is_write_q) begin
        wr_beats_q <= wr_beats_q - CNT_W'(1);
        if (wr_last_beat) begin
          wr_cmd_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_id_q   <= ar_i.id[AXI_ID_WIDTH-1:0];
      rd_addr_q <= ar_i.addr;
    end else if (r_hs) begin
      rd_addr_q <= rd_addr_q + AXI_ADDR_W'(4);
    end
    if (aw_hs) begin
      wr_id_q   <= aw_i.id[AXI_ID_WIDTH-1:0];
      wr_addr_q <= aw_i.addr;
    end else if (rsp_done && cur_is_write_q) begin
      wr_addr_q <= wr_addr_q + AXI_ADDR_W'(4);
    end
    // One buffered W beat
    if (w_hs) begin
      w_q <= w_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= ST_IDLE;
      cur_is_write_q <= 1'b0;
      error_seen_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE) begin
        error_seen_q <= 1'b0;
        if (wr_cmd_q || rd_cmd_q) begin
          cur_is_write_q <= wr_cmd_q;
        end
      end else if (rsp_done && host_rsp_i.err) begin
        error_seen_q <= 1'b1;
      end
    end
  end

  // Engine, a pending write wins over a pending read
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (wr_cmd_q) begin
          state_d = ST_WR_ACT;
        end else if (rd_cmd_q) begin
          state_d = ST_RD_ACT;
        end
      end
      ST_WR_ACT: begin
        if (w_hs) begin
          state_d = ST_ISSUE;
        end
      end
      ST_RD_ACT: begin
        state_d = ST_ISSUE;
      end
      ST_ISSUE: begin
        if (host_gnt_i) begin
          state_d = ST_WAIT_RSP;
        end
      end
      ST_WAIT_RSP: begin
        if (cur_is_write_q) begin
          if (host_rsp_i.rvalid) begin
            state_d = wr_last_beat ? ST_IDLE : ST_WR_ACT;
          end
        end else if (r_hs) begin
          // Hold here until R is taken so the next beat cannot overwrite it
          state_d = rd_last_beat ? ST_IDLE : ST_RD_ACT;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign host_req_valid_o = (state_q == ST_ISSUE);

  always_comb begin
    if (cur_is_write_q) begin
      host_req_o.addr  = wr_addr_q;
      host_req_o.we    = 1'b1;
      host_req_o.be    = w_q.strb;
      host_req_o.wdata = w_q.data;
    end else begin
      host_req_o.addr  = rd_addr_q;
      host_req_o.we    = 1'b0;
      host_req_o.be    = '1;
      host_req_o.wdata = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (rsp_done && !cur_is_write_q) begin
        r_valid_q <= 1'b1;
      end else if (r_hs) begin
        r_valid_q <= 1'b0;
      end
      // One B per burst
      if (rsp_done && cur_is_write_q && wr_last_beat) begin
        b_valid_q <= 1'b1;
      end else if (b_hs) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // R hold buffer, only loaded while R is empty
  always_ff @(posedge clk) begin
    if (rsp_done && !cur_is_write_q) begin
      r_q.id   <= AXI_ID_MAX'(rd_id_q);
      r_q.data <= host_rsp_i.rdata;
      r_q.resp <= beat_resp;
      r_q.last <= rd_last_beat;
    end
    if (rsp_done && cur_is_write_q && wr_last_beat) begin
      b_q.id   <= AXI_ID_MAX'(wr_id_q);
      b_q.resp <= beat_resp;
    end
  end

  assign r_o       = r_q;
  assign r_valid_o = r_valid_q;
  assign b_o       = b_q;
  assign b_valid_o = b_valid_q;

endmodule

/* host_mem.sv */
`timescale 1ns/100ps

module host_mem
  import host_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic      clk,
  input  logic      rst_n,
  input  host_req_t req_i,
  input  logic      req_valid_i,
  output logic      gnt_o,
  output host_rsp_t rsp_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [HOST_DATA_W-1:0] mem_q [MEM_WORDS];

  logic [29:0]            word_idx;
  logic [IDX_W-1:0]       idx;
  logic                   in_range;
  logic                   accept;
  logic                   rvalid_q;
  logic                   err_q;
  logic [HOST_DATA_W-1:0] rdata_q;

  // Low two address bits are ignored
  assign word_idx = req_i.addr[31:2];
  assign idx      = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < 30'(MEM_WORDS));

  // Busy only during the response cycle
  assign gnt_o  = !rvalid_q;
  assign accept = req_valid_i && gnt_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && req_i.we && in_range) begin
      for (int b = 0; b < HOST_BE_W; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= accept;
      if (accept) begin
        err_q <= !in_range;
      end
    end
  end

  // Out-of-range reads and all writes return zero
  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= (in_range && !req_i.we) ? mem_q[idx] : '0;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};

endmodule

/* host_subsys_top.sv */
`timescale 1ns/100ps

module host_subsys_top
  import axi_pkg::*, host_pkg::*;
#(
  parameter int AXI_ID_WIDTH = 4,
  parameter int MEM_WORDS    = 256
) (
  input  logic    clk,
  input  logic    rst_n,
  input  axi_aw_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  input  axi_ar_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  // Internal LSU host port
  host_req_t host_req;
  logic      host_req_valid;
  logic      host_gnt;
  host_rsp_t host_rsp;

  saxi_to_host #(
    .AXI_ID_WIDTH(AXI_ID_WIDTH)
  ) u_bridge (
    .clk              (clk),
    .rst_n            (rst_n),
    .aw_i             (aw_i),
    .aw_valid_i       (aw_valid_i),
    .aw_ready_o       (aw_ready_o),
    .w_i              (w_i),
    .w_valid_i        (w_valid_i),
    .w_ready_o        (w_ready_o),
    .b_o              (b_o),
    .b_valid_o        (b_valid_o),
    .b_ready_i        (b_ready_i),
    .ar_i             (ar_i),
    .ar_valid_i       (ar_valid_i),
    .ar_ready_o       (ar_ready_o),
    .r_o              (r_o),
    .r_valid_o        (r_valid_o),
    .r_ready_i        (r_ready_i),
    .host_req_o       (host_req),
    .host_req_valid_o (host_req_valid),
    .host_gnt_i       (host_gnt),
    .host_rsp_i       (host_rsp)
  );

  host_mem #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (host_req),
    .req_valid_i (host_req_valid),
    .gnt_o       (host_gnt),
    .rsp_o       (host_rsp)
  );

endmodule

/* host_subsys_checker.sv */
`timescale 1ns/100ps

module host_subsys_checker
  import axi_pkg::*, host_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  axi_r_t    r_i,
  input  logic      r_valid_i,
  input  logic      r_ready_i,
  input  axi_b_t    b_i,
  input  logic      b_valid_i,
  input  logic      b_ready_i,
  input  logic      req_valid_i,
  input  logic      gnt_i,
  input  host_rsp_t rsp_i
);

  logic outstanding_q;

  // Number of failed assertions
  int fail_cnt = 0;

  // Host request granted but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (req_valid_i && gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (rsp_i.rvalid) begin
      outstanding_q <= 1'b0;
    end
  end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
    else begin
      $error("R channel dropped or changed while stalled");
      fail_cnt++;
    end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
    else begin
      $error("B channel dropped or changed while stalled");
      fail_cnt++;
    end

  // One host request in flight at a time
  a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req_valid_i) |-> !outstanding_q)
    else begin
      $error("Host request raised while a response was outstanding");
      fail_cnt++;
    end

endmodule

bind saxi_to_host host_subsys_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .r_i         (r_o),
  .r_valid_i   (r_valid_o),
  .r_ready_i   (r_ready_i),
  .b_i         (b_o),
  .b_valid_i   (b_valid_o),
  .b_ready_i   (b_ready_i),
  .req_valid_i (host_req_valid_o),
  .gnt_i       (host_gnt_i),
  .rsp_i       (host_rsp_i)
);

/* tb_host_subsys.sv */
`timescale 1ns/100ps

module tb_host_subsys
  import axi_pkg::*;
();

  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 200;
  localparam logic [31:0] LCG_MUL = 32'd1103515245;
  localparam logic [31:0] LCG_INC = 32'd12345;

  logic    clk;
  logic    rst_n;
  axi_aw_t aw;
  logic    aw_valid;
  logic    aw_ready;
  axi_w_t  w;
  logic    w_valid;
  logic    w_ready;
  axi_b_t  b;
  logic    b_valid;
  logic    b_ready;
  axi_ar_t ar;
  logic    ar_valid;
  logic    ar_ready;
  axi_r_t  r;
  logic    r_valid;
  logic    r_ready;

  // Reference memory, indexed by byte address divided by 4
  logic [31:0] model [MEM_WORDS];
  bit          touched [MEM_WORDS];
  logic [31:0] lcg_state;
  int          err_cnt;
  int          timeout_cnt;
  int          trace_err;
  axi_b_t      got_b;
  axi_r_t      got_r;
  time         b_seen;
  time         r_seen;

  host_subsys_top #(
    .AXI_ID_WIDTH(4),
    .MEM_WORDS   (MEM_WORDS)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .aw_i       (aw),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .b_o        (b),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .ar_i       (ar),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * LCG_MUL + LCG_INC;
    return int'(lcg_state[30:16]) % n;
  endfunction

  function automatic bit in_range(input logic [31:0] a);
    return a[31:2] < MEM_WORDS;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] a);
    return in_range(a) ? model[a[31:2]] : 32'd0;
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
    int idx;
    idx = int'(a[31:2]);
    if (in_range(a)) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          model[idx][8*i +: 8] = d[8*i +: 8];
        end
      end
      touched[idx] = 1'b1;
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // The trace must agree with the address and byte-merge rules
  task automatic check_trace(input int ln, input logic [31:0] a, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp, input bit has_data);
    assert (exp_resp == (in_range(a) ? RESP_OKAY : RESP_SLVERR)) else begin
      $display("Trace line %0d gives a response that does not fit address %h", ln, a);
      trace_err++;
    end
    if (has_data) begin
      assert (exp_data == model_read(a)) else begin
        $display("Trace line %0d expects %h but the model holds %h", ln, exp_data, model_read(a));
        trace_err++;
      end
    end
  endtask

  function automatic logic chan_ready(input int ch);
    return (ch == 0) ? aw_ready : (ch == 1) ? w_ready : ar_ready;
  endfunction

  // Called right after a negedge drive and returns just after the accepting posedge
  task automatic await_accept(input int ch, input string name);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      #1;
      if (chan_ready(ch)) break;
      @(negedge clk);
    end
    if (n == TIMEOUT) begin
      $display("Timeout: the %s channel never accepted its transfer", name);
      timeout_cnt++;
    end else begin
      @(posedge clk);
    end
  endtask

  task automatic send_aw(input logic [7:0] id, input logic [31:0] a);
    @(negedge clk);
    aw = '{id: id, addr: a, len: 8'd0, size: SIZE_WORD, burst: BURST_INCR};
    aw_valid = 1'b1;
    await_accept(0, "AW");
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [31:0] d, input logic [3:0] be);
    @(negedge clk);
    w = '{data: d, strb: be, last: 1'b1};
    w_valid = 1'b1;
    await_accept(1, "W");
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  task automatic send_ar(input logic [7:0] id, input logic [31:0] a);
    @(negedge clk);
    ar = '{id: id, addr: a, len: 8'd0, size: SIZE_WORD, burst: BURST_INCR};
    ar_valid = 1'b1;
    await_accept(2, "AR");
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic write_path(input logic [7:0] id, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] be, input int gap);
    send_aw(id, a);
    repeat (gap) @(negedge clk);
    send_w(d, be);
  endtask

  task automatic take_b(input int stall, output axi_b_t got, output time seen);
    int n;
    got  = '0;
    seen = 0;
    @(negedge clk);
    for (n = 0; n < TIMEOUT; n++) begin
      if (b_valid) break;
      @(negedge clk);
    end
    if (n == TIMEOUT) begin
      $display("Timeout: no write response arrived on B");
      timeout_cnt++;
    end else begin
      seen = $time;
      repeat (stall) @(negedge clk);
      got     = b;
      b_ready = 1'b1;
      @(negedge clk);
      b_ready = 1'b0;
      check_equal("bvalid after handshake", 32'd0, {31'd0, b_valid});
    end
  endtask

  task automatic take_r(input int stall, output axi_r_t got, output time seen);
    int n;
    got  = '0;
    seen = 0;
    @(negedge clk);
    for (n = 0; n < TIMEOUT; n++) begin
      if (r_valid) break;
      @(negedge clk);
    end
    if (n == TIMEOUT) begin
      $display("Timeout: no read data arrived on R");
      timeout_cnt++;
    end else begin
      seen = $time;
      repeat (stall) @(negedge clk);
      got     = r;
      r_ready = 1'b1;
      @(negedge clk);
      r_ready = 1'b0;
      // A single-beat read must leave no second beat behind
      check_equal("rvalid after handshake", 32'd0, {31'd0, r_valid});
    end
  endtask

  task automatic check_b(input logic [7:0] id, input logic [1:0] exp_resp);
    check_equal("bid", {24'd0, id}, {24'd0, got_b.id});
    check_equal("bresp", {30'd0, exp_resp}, {30'd0, got_b.resp});
  endtask

  task automatic check_r(input logic [7:0] id, input logic [31:0] exp_data,
                         input logic [1:0] exp_resp);
    check_equal("rid", {24'd0, id}, {24'd0, got_r.id});
    check_equal("rdata", exp_data, got_r.data);
    check_equal("rresp", {30'd0, exp_resp}, {30'd0, got_r.resp});
    check_equal("rlast", 32'd1, {31'd0, got_r.last});
  endtask

  initial begin
    int          fd;
    int          code;
    int          ln;
    int          gap;
    int          bst;
    int          rst;
    int          proto_err;
    string       line;
    logic [7:0]  op;
    logic [7:0]  id;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;

    rst_n    = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    lcg_state   = 32'd52552;
    err_cnt     = 0;
    timeout_cnt = 0;
    trace_err   = 0;
    ln          = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i]   = '0;
      touched[i] = 1'b0;
    end
    // Word 0 is where 0x400 would land if the range check were missing
    touched[0] = 1'b1;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_equal("bvalid after reset", 32'd0, {31'd0, b_valid});
    check_equal("rvalid after reset", 32'd0, {31'd0, r_valid});
    check_equal("wready after reset", 32'd0, {31'd0, w_ready});
    check_equal("req_valid after reset", 32'd0, {31'd0, dut_i.host_req_valid});

    fd = $fopen("host_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file host_trace.txt");
      trace_err++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        ln++;
        if (code == 0 || line.len() < 2 || line[0] == "#") begin
          continue;
        end
        code = $sscanf(line, "%s %h %h %h %h %h %h", op, id, addr, wdata, strb,
                       exp_data, exp_resp);
        if (code != 7) begin
          $display("Trace line %0d could not be parsed", ln);
          trace_err++;
          continue;
        end
        gap = rand_below(3);
        bst = rand_below(4);
        rst = rand_below(4);
        case (op)
          "W": begin
            fork
              write_path(id, addr, wdata, strb, gap);
              take_b(bst, got_b, b_seen);
            join
            model_write(addr, wdata, strb);
            check_trace(ln, addr, exp_data, exp_resp, 1'b0);
            check_b(id, exp_resp);
          end
          "R": begin
            fork
              send_ar(id, addr);
              take_r(rst, got_r, r_seen);
            join
            check_trace(ln, addr, exp_data, exp_resp, 1'b1);
            check_r(id, exp_data, exp_resp);
          end
          "B": begin
            // AW and AR leave in the same cycle and the write must win
            fork
              write_path(id, addr, wdata, strb, gap);
              send_ar(id, addr);
              take_b(bst, got_b, b_seen);
              take_r(rst, got_r, r_seen);
            join
            model_write(addr, wdata, strb);
            check_trace(ln, addr, exp_data, exp_resp, 1'b1);
            check_b(id, exp_resp);
            check_r(id, exp_data, exp_resp);
            assert (b_seen < r_seen) else begin
              $display("Write response on line %0d did not come before the read data", ln);
              err_cnt++;
            end
          end
          default: begin
            $display("Trace line %0d has an unknown operation", ln);
            trace_err++;
          end
        endcase
      end
      $fclose(fd);
    end

    // Read back every written word and word 0
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (touched[i]) begin
        fork
          send_ar(8'd0, 32'(i) << 2);
          take_r(rand_below(4), got_r, r_seen);
        join
        check_r(8'd0, model[i], RESP_OKAY);
      end
    end

    proto_err = dut_i.u_bridge.u_checker.fail_cnt;
    $display("Checks done: %0d value errors, %0d timeouts, %0d trace errors, %0d protocol errors",
             err_cnt, timeout_cnt, trace_err, proto_err);
    if (err_cnt == 0 && timeout_cnt == 0 && trace_err == 0 && proto_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
axi_pkg.sv
host_pkg.sv
saxi_to_host.sv
host_mem.sv
host_subsys_top.sv
host_subsys_checker.sv
tb_host_subsys.sv

/* host_trace.txt */
# op id addr wdata strb exp_rdata exp_resp, all but op in hex
# op W writes, R reads, B issues the write and the read in the same cycle
W 1 00000010 deadbeef f 00000000 0
R 2 00000010 00000000 0 deadbeef 0
W 3 00000010 11223344 3 00000000 0
R 4 00000010 00000000 0 dead3344 0
W 5 00000010 aabbccdd c 00000000 0
R 6 00000010 00000000 0 aabb3344 0
W 7 00000023 cafef00d f 00000000 0
R 8 00000020 00000000 0 cafef00d 0
R 9 00000021 00000000 0 cafef00d 0
W a 00000046 12345678 5 00000000 0
R b 00000044 00000000 0 00340078 0
R c 00000047 00000000 0 00340078 0
W d 00000400 ffffffff f 00000000 2
R e 00000400 00000000 0 00000000 2
R f 000007fc 00000000 0 00000000 2
R 1 80000000 00000000 0 00000000 2
W 2 000003fc 0badf00d f 00000000 0
R 3 000003fc 00000000 0 0badf00d 0
B 4 00000010 55667788 f 55667788 0
B 5 00000080 a5a5a5a5 6 00a5a500 0
R 6 00000080 00000000 0 00a5a500 0
B 7 00000400 01020304 f 00000000 2
R 8 00000000 00000000 0 00000000 0
R 9 00000010 00000000 0 55667788 0
